/* build.f */
vai_pkg.sv
vai_offset_regs.sv
vai_audit_tx.sv
vai_tx_arbiter.sv
vai_rx_demux.sv
vai_mux_top.sv
tb_vai_mux.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vai_mux
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Finished with no errors

.PHONY: sim clean

# The log decides pass or fail, the simulator exit code is not used.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_vai_mux.sv */
`timescale 1ns/1ps

module tb_vai_mux;

    import vai_pkg::*;

    localparam int TIMEOUT_CYCLES = 300;

    logic      clk;
    logic      rst;
    logic      cfg_wr;
    t_port_idx cfg_idx;
    t_offset   cfg_offset;
    logic      afu_req_valid   [NUM_SUB_AFUS-1:0];
    t_req_type afu_req_type    [NUM_SUB_AFUS-1:0];
    t_cl_addr  afu_req_addr    [NUM_SUB_AFUS-1:0];
    t_mdata    afu_req_mdata   [NUM_SUB_AFUS-1:0];
    t_data     afu_req_data    [NUM_SUB_AFUS-1:0];
    logic      afu_almost_full [NUM_SUB_AFUS-1:0];
    logic      up_req_valid;
    t_req_type up_req_type;
    t_cl_addr  up_req_addr;
    t_mdata    up_req_mdata;
    t_data     up_req_data;
    logic      up_almost_full;
    logic      up_rsp_valid;
    t_mdata    up_rsp_mdata;
    t_data     up_rsp_data;
    logic      afu_rsp_valid   [NUM_SUB_AFUS-1:0];
    t_mdata    afu_rsp_mdata   [NUM_SUB_AFUS-1:0];
    t_data     afu_rsp_data    [NUM_SUB_AFUS-1:0];

    t_port_idx req_port  [$];
    t_req_type req_type  [$];
    t_cl_addr  req_addr  [$];
    t_mdata    req_mdata [$];
    t_data     req_data  [$];
    logic      req_join  [$];  // Row leaves in the same cycle as the row before.

    t_port_idx rsp_tag   [$];
    t_mdata    rsp_mdata [$];
    t_data     rsp_data  [$];

    t_offset   model_offset [NUM_SUB_AFUS];
    t_req_type exp_type     [NUM_SUB_AFUS][$];
    t_cl_addr  exp_addr     [NUM_SUB_AFUS][$];
    t_mdata    exp_mdata    [NUM_SUB_AFUS][$];
    t_data     exp_data     [NUM_SUB_AFUS][$];

    int        sent_count;
    int        recv_count;
    int        seed;
    int        cycles;
    string     test_name;
    logic      uaf_at_edge;  // Upstream almost-full as seen by the last edge.

    vai_mux_top i_dut (.*);

    always #50 clk = ~clk;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_addr(input string what, input t_cl_addr exp, input t_cl_addr act);
        if (act !== exp)
        begin
            stop_with_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic check_mdata(input string what, input t_mdata exp, input t_mdata act);
        if (act !== exp)
        begin
            stop_with_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic check_data(input string what, input t_data exp, input t_data act);
        if (act !== exp)
        begin
            stop_with_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic check_type(input string what, input t_req_type exp, input t_req_type act);
        if (act !== exp)
        begin
            stop_with_error($sformatf("[FAIL] %s %s: expected %0d, actual %0d",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            stop_with_error($sformatf("[FAIL] %s %s: expected %b, actual %b",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic add_req(input t_port_idx p, input t_req_type t, input t_cl_addr a,
                           input t_mdata m, input t_data d, input logic j);
        req_port.push_back(p);
        req_type.push_back(t);
        req_addr.push_back(a);
        req_mdata.push_back(m);
        req_data.push_back(d);
        req_join.push_back(j);
    endtask

    // Expected upstream request, built from the relocation and tag rules.
    task automatic model_push(input int i);
        t_port_idx p;
        t_cl_addr  sum;
        p = req_port[i];
        if (req_type[i] == REQ_WRFENCE)
        begin
            sum = '0;
        end
        else
        begin
            sum = req_addr[i] + model_offset[p][41:0];
        end
        exp_type[p].push_back(req_type[i]);
        exp_addr[p].push_back({sum[39:15], p, sum[14:0]});
        exp_mdata[p].push_back({p, req_mdata[i][13:0]});
        exp_data[p].push_back(req_data[i]);
        sent_count++;
    endtask

    task automatic write_offset(input t_port_idx p, input t_offset off);
        @(posedge clk);
        #1;
        cfg_wr     = 1'b1;
        cfg_idx    = p;
        cfg_offset = off;
        @(posedge clk);
        #1;
        cfg_wr          = 1'b0;
        model_offset[p] = off;
    endtask

    task automatic apply_requests(input logic use_gaps);
        int   i;
        int   last;
        int   gap;
        int   tries;
        logic blocked;
        i = 0;
        while (i < req_port.size())
        begin
            last = i;
            while ((last + 1 < req_port.size()) && req_join[last + 1])
            begin
                last++;
            end
            gap = use_gaps ? int'($unsigned($random(seed)) % 3) : 0;
            repeat (gap)
            begin
                @(posedge clk);
                #1;
            end
            tries   = 0;
            blocked = 1'b1;
            while (blocked)
            begin
                blocked = 1'b0;
                for (int k = i; k <= last; k++)
                begin
                    blocked = blocked | afu_almost_full[req_port[k]];
                end
                if (blocked && (tries >= TIMEOUT_CYCLES))
                begin
                    stop_with_error("Timeout waiting for a port's almost-full to drop");
                end
                else if (blocked)
                begin
                    tries++;
                    @(posedge clk);
                    #1;
                end
            end
            for (int k = i; k <= last; k++)
            begin
                afu_req_valid[req_port[k]] = 1'b1;
                afu_req_type[req_port[k]]  = req_type[k];
                afu_req_addr[req_port[k]]  = req_addr[k];
                afu_req_mdata[req_port[k]] = req_mdata[k];
                afu_req_data[req_port[k]]  = req_data[k];
                model_push(k);
            end
            @(posedge clk);
            #1;
            for (int n = 0; n < NUM_SUB_AFUS; n++)
            begin
                afu_req_valid[n] = 1'b0;
            end
            i = last + 1;
        end
        req_port.delete();
        req_type.delete();
        req_addr.delete();
        req_mdata.delete();
        req_data.delete();
        req_join.delete();
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (recv_count != sent_count)
        begin
            if (waited >= TIMEOUT_CYCLES)
            begin
                stop_with_error($sformatf("Timeout in %s: only %0d of %0d requests issued",
                                          test_name, recv_count, sent_count));
            end
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic apply_responses();
        for (int i = 0; i < rsp_tag.size(); i++)
        begin
            @(posedge clk);
            #1;
            up_rsp_valid = 1'b1;
            up_rsp_mdata = {rsp_tag[i], rsp_mdata[i][13:0]};
            up_rsp_data  = rsp_data[i];
            @(negedge clk);
            for (int n = 0; n < NUM_SUB_AFUS; n++)
            begin
                check_flag("afu_rsp_valid too early", 1'b0, afu_rsp_valid[n]);
            end
            @(posedge clk);
            #1;
            up_rsp_valid = 1'b0;
            @(negedge clk);
            for (int n = 0; n < NUM_SUB_AFUS; n++)
            begin
                check_flag($sformatf("afu_rsp_valid[%0d]", n), t_port_idx'(n) == rsp_tag[i],
                           afu_rsp_valid[n]);
            end
            check_mdata("afu_rsp_mdata", {2'b00, rsp_mdata[i][13:0]}, afu_rsp_mdata[rsp_tag[i]]);
            check_data("afu_rsp_data", rsp_data[i], afu_rsp_data[rsp_tag[i]]);
        end
    endtask

    always @(negedge clk)
    begin : upstream_monitor
        t_port_idx p;
        if (uaf_at_edge && (up_req_valid === 1'b1))
        begin
            stop_with_error("Upstream request issued on an edge with upstream almost-full high");
        end
        else if (up_req_valid === 1'b1)
        begin
            p = up_req_mdata[15:14];  // Tag names the owning port.
            if (exp_addr[p].size() == 0)
            begin
                stop_with_error($sformatf("Unexpected upstream request for port %0d in %s",
                                          p, test_name));
            end
            else
            begin
                check_type("up_req_type", exp_type[p][0], up_req_type);
                check_addr("up_req_addr", exp_addr[p][0], up_req_addr);
                check_mdata("up_req_mdata", exp_mdata[p][0], up_req_mdata);
                check_data("up_req_data", exp_data[p][0], up_req_data);
                exp_type[p].delete(0);
                exp_addr[p].delete(0);
                exp_mdata[p].delete(0);
                exp_data[p].delete(0);
                recv_count++;
            end
        end
        uaf_at_edge = up_almost_full;
    end

    initial
    begin
        seed           = 58617;
        clk            = 1'b0;
        rst            = 1'b1;
        cfg_wr         = 1'b0;
        cfg_idx        = '0;
        cfg_offset     = '0;
        up_almost_full = 1'b0;
        up_rsp_valid   = 1'b0;
        up_rsp_mdata   = '0;
        up_rsp_data    = '0;
        sent_count     = 0;
        recv_count     = 0;
        uaf_at_edge    = 1'b0;
        for (int n = 0; n < NUM_SUB_AFUS; n++)
        begin
            afu_req_valid[n] = 1'b0;
            afu_req_type[n]  = REQ_RDLINE;
            afu_req_addr[n]  = '0;
            afu_req_mdata[n] = '0;
            afu_req_data[n]  = '0;
            model_offset[n]  = '0;
        end

        test_name = "reset";
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (5) @(posedge clk);  // Covers the registered reset inside the top.
        @(negedge clk);
        check_flag("up_req_valid", 1'b0, up_req_valid);
        for (int n = 0; n < NUM_SUB_AFUS; n++)
        begin
            check_flag("afu_almost_full", 1'b0, afu_almost_full[n]);
            check_flag("afu_rsp_valid", 1'b0, afu_rsp_valid[n]);
        end

        test_name = "relocation";
        write_offset(2'd0, 64'h0000_0000_0000_1000);
        write_offset(2'd1, 64'h0000_0000_0123_4567);
        write_offset(2'd2, 64'hFFFF_FC00_0000_8000);  // Bits above 41 are dropped.
        write_offset(2'd3, 64'h0000_0000_0000_7FFF);  // Carries across bit 15.
        add_req(2'd0, REQ_RDLINE, 42'h000_0000_1234, 16'hC001, 64'h0101_0101_0101_0101, 1'b0);
        add_req(2'd1, REQ_WRLINE, 42'h012_3456_789A, 16'h4002, 64'hDEAD_BEEF_0000_0002, 1'b0);
        add_req(2'd2, REQ_RDLINE, 42'h3FF_0000_7FFF, 16'h8003, 64'h0202_0202_0202_0202, 1'b0);
        add_req(2'd3, REQ_WRLINE, 42'h000_0000_4001, 16'h0004, 64'hCAFE_F00D_1234_5678, 1'b0);
        add_req(2'd3, REQ_RDLINE, 42'h1AB_CDEF_0123, 16'hFFFF, 64'h0303_0303_0303_0303, 1'b0);
        add_req(2'd2, REQ_WRLINE, 42'h000_0001_0000, 16'h1005, 64'h8000_0000_0000_0001, 1'b0);
        add_req(2'd1, REQ_RDLINE, 42'h3FF_FFFF_FFFF, 16'h2006, 64'h0404_0404_0404_0404, 1'b0);
        add_req(2'd0, REQ_WRLINE, 42'h155_5555_5555, 16'h3007, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
        apply_requests(1'b1);
        wait_drain();

        test_name = "fence";
        add_req(2'd1, REQ_WRFENCE, 42'h123_4567_89AB, 16'hC010, 64'h0000_0000_0000_0F0F, 1'b0);
        add_req(2'd3, REQ_WRFENCE, 42'h3FF_FFFF_FFFF, 16'h0011, 64'h0000_0000_0000_F0F0, 1'b0);
        apply_requests(1'b1);
        wait_drain();

        test_name = "sharing";
        for (int g = 0; g < 4; g++)
        begin
            for (int p = 0; p < NUM_SUB_AFUS; p++)
            begin
                add_req(t_port_idx'(p), (((g + p) % 2) == 1) ? REQ_WRLINE : REQ_RDLINE,
                        {26'h2A5, 8'(g), 8'(p)}, {8'(g), 8'(p)},
                        {32'(g), 32'(p)} ^ 64'h5A5A_0000_0000_5A5A, p != 0);
            end
        end
        apply_requests(1'b1);
        wait_drain();

        test_name = "backpressure";
        @(posedge clk);
        #1;
        up_almost_full = 1'b1;
        add_req(2'd0, REQ_RDLINE, 42'h000_0000_0100, 16'h0020, 64'h1000_0000_0000_0001, 1'b0);
        add_req(2'd0, REQ_WRLINE, 42'h000_0000_0101, 16'h0021, 64'h1000_0000_0000_0002, 1'b0);
        add_req(2'd0, REQ_RDLINE, 42'h000_0000_0102, 16'h0022, 64'h1000_0000_0000_0003, 1'b0);
        add_req(2'd0, REQ_WRLINE, 42'h000_0000_0103, 16'h0023, 64'h1000_0000_0000_0004, 1'b0);
        apply_requests(1'b0);
        cycles = 0;
        while (afu_almost_full[0] !== 1'b1)
        begin
            if (cycles >= TIMEOUT_CYCLES)
            begin
                stop_with_error("Timeout waiting for almost-full of port 0 to rise");
            end
            @(negedge clk);
            cycles++;
        end
        repeat (4) @(posedge clk);
        #1;
        up_almost_full = 1'b0;
        wait_drain();

        test_name = "offset_update";
        write_offset(2'd2, 64'h0000_0000_0ABC_D000);
        add_req(2'd2, REQ_RDLINE, 42'h000_0000_1000, 16'h0030, 64'h2000_0000_0000_0001, 1'b0);
        add_req(2'd1, REQ_RDLINE, 42'h000_0000_1000, 16'h0031, 64'h2000_0000_0000_0002, 1'b0);
        add_req(2'd2, REQ_WRLINE, 42'h0F0_0000_8000, 16'h0032, 64'h2000_0000_0000_0003, 1'b0);
        add_req(2'd0, REQ_WRLINE, 42'h000_0000_1000, 16'h0033, 64'h2000_0000_0000_0004, 1'b0);
        apply_requests(1'b1);
        wait_drain();

        test_name = "response";
        rsp_tag   = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd2};
        rsp_mdata = '{16'h0123, 16'h3FFF, 16'h0000, 16'h2A5A, 16'h1111};
        rsp_data  = '{64'h0123_4567_89AB_CDEF, 64'hFFFF_0000_FFFF_0000,
                      64'h0000_0000_0000_0000, 64'hA5A5_A5A5_5A5A_5A5A,
                      64'h1111_2222_3333_4444};
        apply_responses();

        repeat (3) @(posedge clk);
        if ((recv_count == sent_count) && (exp_addr[0].size() == 0) &&
            (exp_addr[1].size() == 0) && (exp_addr[2].size() == 0) &&
            (exp_addr[3].size() == 0))
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
        begin
            $display("Requests still expected upstream at the end of the run");
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

/* vai_mux_top.sv */
`timescale 1ns/1ps

module vai_mux_top
(
    input  logic                clk,
    input  logic                rst,
    input  logic                cfg_wr,
    input  vai_pkg::t_port_idx  cfg_idx,
    input  vai_pkg::t_offset    cfg_offset,
    input  logic                afu_req_valid   [vai_pkg::NUM_SUB_AFUS-1:0],
    input  vai_pkg::t_req_type  afu_req_type    [vai_pkg::NUM_SUB_AFUS-1:0],
    input  vai_pkg::t_cl_addr   afu_req_addr    [vai_pkg::NUM_SUB_AFUS-1:0],
    input  vai_pkg::t_mdata     afu_req_mdata   [vai_pkg::NUM_SUB_AFUS-1:0],
    input  vai_pkg::t_data      afu_req_data    [vai_pkg::NUM_SUB_AFUS-1:0],
    output logic                afu_almost_full [vai_pkg::NUM_SUB_AFUS-1:0],
    output logic                up_req_valid,
    output vai_pkg::t_req_type  up_req_type,
    output vai_pkg::t_cl_addr   up_req_addr,
    output vai_pkg::t_mdata     up_req_mdata,
    output vai_pkg::t_data      up_req_data,
    input  logic                up_almost_full,
    input  logic                up_rsp_valid,
    input  vai_pkg::t_mdata     up_rsp_mdata,
    input  vai_pkg::t_data      up_rsp_data,
    output logic                afu_rsp_valid   [vai_pkg::NUM_SUB_AFUS-1:0],
    output vai_pkg::t_mdata     afu_rsp_mdata   [vai_pkg::NUM_SUB_AFUS-1:0],
    output vai_pkg::t_data      afu_rsp_data    [vai_pkg::NUM_SUB_AFUS-1:0]
);

    import vai_pkg::*;

    logic      rst_q;
    t_offset   offset   [NUM_SUB_AFUS-1:0];
    logic      tx_valid [NUM_SUB_AFUS-1:0];
    t_req_type tx_type  [NUM_SUB_AFUS-1:0];
    t_cl_addr  tx_addr  [NUM_SUB_AFUS-1:0];
    t_mdata    tx_mdata [NUM_SUB_AFUS-1:0];
    t_data     tx_data  [NUM_SUB_AFUS-1:0];

    always_ff @(posedge clk)
    begin
        rst_q <= rst;  // Local copy of reset drives all blocks.
    end

    vai_offset_regs i_offset_regs
    (
        .clk        (clk),
        .rst        (rst_q),
        .cfg_wr     (cfg_wr),
        .cfg_idx    (cfg_idx),
        .cfg_offset (cfg_offset),
        .offset     (offset)
    );

    for (genvar n = 0; n < NUM_SUB_AFUS; n++)
    begin : g_port
        vai_audit_tx i_audit_tx
        (
            .clk           (clk),
            .rst           (rst_q),
            .port_idx      (t_port_idx'(n)),
            .offset        (offset[n]),
            .afu_req_valid (afu_req_valid[n]),
            .afu_req_type  (afu_req_type[n]),
            .afu_req_addr  (afu_req_addr[n]),
            .afu_req_mdata (afu_req_mdata[n]),
            .afu_req_data  (afu_req_data[n]),
            .tx_valid      (tx_valid[n]),
            .tx_type       (tx_type[n]),
            .tx_addr       (tx_addr[n]),
            .tx_mdata      (tx_mdata[n]),
            .tx_data       (tx_data[n])
        );
    end

    vai_tx_arbiter i_tx_arbiter
    (
        .clk              (clk),
        .rst              (rst_q),
        .tx_valid         (tx_valid),
        .tx_type          (tx_type),
        .tx_addr          (tx_addr),
        .tx_mdata         (tx_mdata),
        .tx_data          (tx_data),
        .port_almost_full (afu_almost_full),
        .up_almost_full   (up_almost_full),
        .up_req_valid     (up_req_valid),
        .up_req_type      (up_req_type),
        .up_req_addr      (up_req_addr),
        .up_req_mdata     (up_req_mdata),
        .up_req_data      (up_req_data)
    );

    vai_rx_demux i_rx_demux
    (
        .clk           (clk),
        .rst           (rst_q),
        .up_rsp_valid  (up_rsp_valid),
        .up_rsp_mdata  (up_rsp_mdata),
        .up_rsp_data   (up_rsp_data),
        .afu_rsp_valid (afu_rsp_valid),
        .afu_rsp_mdata (afu_rsp_mdata),
        .afu_rsp_data  (afu_rsp_data)
    );

endmodule

/* vai_rx_demux.sv */
`timescale 1ns/1ps

module vai_rx_demux
(
    input  logic                clk,
    input  logic                rst,
    input  logic                up_rsp_valid,
    input  vai_pkg::t_mdata     up_rsp_mdata,
    input  vai_pkg::t_data      up_rsp_data,
    output logic                afu_rsp_valid [vai_pkg::NUM_SUB_AFUS-1:0],
    output vai_pkg::t_mdata     afu_rsp_mdata [vai_pkg::NUM_SUB_AFUS-1:0],
    output vai_pkg::t_data      afu_rsp_data  [vai_pkg::NUM_SUB_AFUS-1:0]
);

    import vai_pkg::*;

    t_port_idx rsp_tag;
    t_mdata    rsp_mdata_clr;
    logic      hit [NUM_SUB_AFUS-1:0];

    assign rsp_tag       = up_rsp_mdata[MDATA_TAG_LSB +: VMID_WIDTH];
    assign rsp_mdata_clr = {{VMID_WIDTH{1'b0}}, up_rsp_mdata[MDATA_TAG_LSB-1:0]};

    always_comb
    begin
        for (int i = 0; i < NUM_SUB_AFUS; i++)
        begin
            hit[i] = up_rsp_valid && (rsp_tag == t_port_idx'(i));
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_SUB_AFUS; i++)
            begin
                afu_rsp_valid[i] <= 1'b0;
            end
        end
        else
        begin
            for (int i = 0; i < NUM_SUB_AFUS; i++)
            begin
                afu_rsp_valid[i] <= hit[i];
            end
        end
    end

    // Payload only loads on the owning port.
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_SUB_AFUS; i++)
        begin
            if (hit[i])
            begin
                afu_rsp_mdata[i] <= rsp_mdata_clr;
                afu_rsp_data[i]  <= up_rsp_data;
            end
        end
    end

endmodule

/* vai_tx_arbiter.sv */
`timescale 1ns/1ps

module vai_tx_arbiter
(
    input  logic                clk,
    input  logic                rst,
    input  logic                tx_valid         [vai_pkg::NUM_SUB_AFUS-1:0],
    input  vai_pkg::t_req_type  tx_type          [vai_pkg::NUM_SUB_AFUS-1:0],
    input  vai_pkg::t_cl_addr   tx_addr          [vai_pkg::NUM_SUB_AFUS-1:0],
    input  vai_pkg::t_mdata     tx_mdata         [vai_pkg::NUM_SUB_AFUS-1:0],
    input  vai_pkg::t_data      tx_data          [vai_pkg::NUM_SUB_AFUS-1:0],
    output logic                port_almost_full [vai_pkg::NUM_SUB_AFUS-1:0],
    input  logic                up_almost_full,
    output logic                up_req_valid,
    output vai_pkg::t_req_type  up_req_type,
    output vai_pkg::t_cl_addr   up_req_addr,
    output vai_pkg::t_mdata     up_req_mdata,
    output vai_pkg::t_data      up_req_data
);

    import vai_pkg::*;

    t_req_type q_type  [NUM_SUB_AFUS-1:0][QUEUE_DEPTH-1:0];
    t_cl_addr  q_addr  [NUM_SUB_AFUS-1:0][QUEUE_DEPTH-1:0];
    t_mdata    q_mdata [NUM_SUB_AFUS-1:0][QUEUE_DEPTH-1:0];
    t_data     q_data  [NUM_SUB_AFUS-1:0][QUEUE_DEPTH-1:0];

    t_q_ptr    wr_ptr [NUM_SUB_AFUS-1:0];
    t_q_ptr    rd_ptr [NUM_SUB_AFUS-1:0];
    t_q_count  count  [NUM_SUB_AFUS-1:0];
    logic      push   [NUM_SUB_AFUS-1:0];
    logic      pop    [NUM_SUB_AFUS-1:0];

    t_port_idx last_grant;
    t_port_idx grant_idx;
    logic      grant_any;
    logic      issue;

    // Search starts one past the last winner.
    always_comb
    begin
        t_port_idx cand;
        cand      = last_grant;
        grant_any = 1'b0;
        grant_idx = last_grant;
        for (int k = 1; k <= NUM_SUB_AFUS; k++)
        begin
            cand = t_port_idx'(last_grant + k);
            if (!grant_any && (count[cand] != '0))
            begin
                grant_any = 1'b1;
                grant_idx = cand;
            end
        end
    end

    assign issue = grant_any && !up_almost_full;

    always_comb
    begin
        for (int i = 0; i < NUM_SUB_AFUS; i++)
        begin
            push[i] = tx_valid[i] && (count[i] != t_q_count'(QUEUE_DEPTH));
            pop[i]  = issue && (grant_idx == t_port_idx'(i));
            port_almost_full[i] = (count[i] >= t_q_count'(ALMOST_FULL_LEVEL));
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_SUB_AFUS; i++)
        begin
            if (push[i])
            begin
                q_type[i][wr_ptr[i]]  <= tx_type[i];
                q_addr[i][wr_ptr[i]]  <= tx_addr[i];
                q_mdata[i][wr_ptr[i]] <= tx_mdata[i];
                q_data[i][wr_ptr[i]]  <= tx_data[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_SUB_AFUS; i++)
            begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i]  <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < NUM_SUB_AFUS; i++)
            begin
                if (push[i])
                begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;
                end
                if (pop[i])
                begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end
                count[i] <= count[i] + t_q_count'(push[i]) - t_q_count'(pop[i]);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            up_req_valid <= 1'b0;
            last_grant   <= t_port_idx'(NUM_SUB_AFUS-1);  // Port 0 wins first.
        end
        else
        begin
            up_req_valid <= issue;
            if (issue)
            begin
                last_grant <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            up_req_type  <= q_type[grant_idx][rd_ptr[grant_idx]];
            up_req_addr  <= q_addr[grant_idx][rd_ptr[grant_idx]];
            up_req_mdata <= q_mdata[grant_idx][rd_ptr[grant_idx]];
            up_req_data  <= q_data[grant_idx][rd_ptr[grant_idx]];
        end
    end

endmodule

/* vai_audit_tx.sv */
`timescale 1ns/1ps

module vai_audit_tx
(
    input  logic                clk,
    input  logic                rst,
    input  vai_pkg::t_port_idx  port_idx,
    input  vai_pkg::t_offset    offset,
    input  logic                afu_req_valid,
    input  vai_pkg::t_req_type  afu_req_type,
    input  vai_pkg::t_cl_addr   afu_req_addr,
    input  vai_pkg::t_mdata     afu_req_mdata,
    input  vai_pkg::t_data      afu_req_data,
    output logic                tx_valid,
    output vai_pkg::t_req_type  tx_type,
    output vai_pkg::t_cl_addr   tx_addr,
    output vai_pkg::t_mdata     tx_mdata,
    output vai_pkg::t_data      tx_data
);

    import vai_pkg::*;

    // Stage 1
    logic      s1_valid;
    t_req_type s1_type;
    t_cl_addr  s1_addr;
    t_mdata    s1_mdata;
    t_data     s1_data;
    t_offset   s1_offset;

    // Stage 2
    logic      s2_valid;
    t_req_type s2_type;
    t_cl_addr  s2_sum;
    t_mdata    s2_mdata;
    t_data     s2_data;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= afu_req_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        s1_type   <= afu_req_type;
        s1_addr   <= afu_req_addr;
        s1_mdata  <= afu_req_mdata;
        s1_data   <= afu_req_data;
        s1_offset <= offset;  // Offset sampled alongside the request.
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s2_valid <= 1'b0;
        end
        else
        begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        s2_type <= s1_type;
        s2_data <= s1_data;
        if (s1_type == REQ_WRFENCE)
        begin
            s2_sum <= '0;  // Fences carry no address.
        end
        else
        begin
            s2_sum <= s1_addr + s1_offset[CL_ADDR_WIDTH-1:0];
        end
        s2_mdata <= {port_idx, s1_mdata[MDATA_TAG_LSB-1:0]};  // Tag marks the owning port.
    end

    // VM id goes in above the low page bits, upper bits shift up.
    always_comb
    begin
        tx_addr[VMID_LSB-1:0]                          = s2_sum[VMID_LSB-1:0];
        tx_addr[VMID_LSB +: VMID_WIDTH]                = port_idx;
        tx_addr[CL_ADDR_WIDTH-1:VMID_LSB+VMID_WIDTH]   =
            s2_sum[CL_ADDR_WIDTH-1-VMID_WIDTH:VMID_LSB];
    end

    assign tx_valid = s2_valid;
    assign tx_type  = s2_type;
    assign tx_mdata = s2_mdata;
    assign tx_data  = s2_data;

endmodule

/* vai_offset_regs.sv */
`timescale 1ns/1ps

module vai_offset_regs
(
    input  logic                clk,
    input  logic                rst,
    input  logic                cfg_wr,
    input  vai_pkg::t_port_idx  cfg_idx,
    input  vai_pkg::t_offset    cfg_offset,
    output vai_pkg::t_offset    offset [vai_pkg::NUM_SUB_AFUS-1:0]
);

    import vai_pkg::*;

    t_offset offset_q [NUM_SUB_AFUS-1:0];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_SUB_AFUS; i++)
            begin
                offset_q[i] <= '0;
            end
        end
        else if (cfg_wr)
        begin
            offset_q[cfg_idx] <= cfg_offset;  // Applies to requests entering stage 1 next.
        end
    end

    always_comb
    begin
        for (int i = 0; i < NUM_SUB_AFUS; i++)
        begin
            offset[i] = offset_q[i];
        end
    end

endmodule

/* vai_pkg.sv */
package vai_pkg;

    localparam int NUM_SUB_AFUS      = 4;
    localparam int VMID_WIDTH        = 2;   // Bits of port index.

    localparam int CL_ADDR_WIDTH     = 42;
    localparam int MDATA_WIDTH       = 16;
    localparam int DATA_WIDTH        = 64;
    localparam int OFFSET_WIDTH      = 64;
    localparam int REQ_TYPE_WIDTH    = 2;

    localparam int MDATA_TAG_LSB     = 14;  // Tag occupies mdata[15:14].
    localparam int VMID_LSB          = 15;  // VM id lands in address[16:15].

    localparam int QUEUE_DEPTH       = 4;
    localparam int QUEUE_PTR_WIDTH   = $clog2(QUEUE_DEPTH);
    localparam int ALMOST_FULL_LEVEL = 2;

    typedef logic [CL_ADDR_WIDTH-1:0]   t_cl_addr;
    typedef logic [MDATA_WIDTH-1:0]     t_mdata;
    typedef logic [DATA_WIDTH-1:0]      t_data;
    typedef logic [OFFSET_WIDTH-1:0]    t_offset;
    typedef logic [REQ_TYPE_WIDTH-1:0]  t_req_type;
    typedef logic [VMID_WIDTH-1:0]      t_port_idx;

    typedef logic [QUEUE_PTR_WIDTH-1:0] t_q_ptr;
    typedef logic [QUEUE_PTR_WIDTH:0]   t_q_count;  // One extra bit to hold a full count.

    localparam t_req_type REQ_RDLINE  = 2'd0;
    localparam t_req_type REQ_WRLINE  = 2'd1;
    localparam t_req_type REQ_WRFENCE = 2'd2;

endpackage
